// File: src/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus data width
`define HDATA_W 32

// Word address widths of the TCMs
`define ITCM_AW 14
`define DTCM_AW 13

// Memory map
`define ITCM_BASE   32'h0000_0000
`define DTCM_BASE   32'h2000_0000
`define REGION_MASK 32'hF000_0000

`endif

// File: src/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // AHB transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hsize_e;

    // Owner of the current data phase
    typedef enum logic [1:0] {
        SEL_ITCM,
        SEL_DTCM,
        SEL_DEFAULT
    } slave_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ_WAIT
    } sram_state_e;

    typedef enum logic {
        ERR_IDLE,
        ERR_FIRST
    } err_state_e;

endpackage : soc_pkg

`default_nettype wire

// File: src/ahb_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module ahb_decoder
    import soc_pkg::*;
(
    input  logic        clk        ,
    input  logic        rst_n      ,
    input  logic [31:0] haddr      ,
    input  htrans_e     htrans     ,
    input  logic        hready     ,
    output logic        sel_itcm   ,
    output logic        sel_dtcm   ,
    output logic        sel_default,
    output slave_sel_e  data_sel
);

    logic active;

    assign active = (htrans == NONSEQ) || (htrans == SEQ);

    // Region compare on the top nibble
    assign sel_itcm    = (haddr & `REGION_MASK) == (`ITCM_BASE & `REGION_MASK);
    assign sel_dtcm    = (haddr & `REGION_MASK) == (`DTCM_BASE & `REGION_MASK);
    assign sel_default = !sel_itcm && !sel_dtcm;

    // Response path follows the accepted address phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sel <= SEL_DEFAULT;
        end else if (hready) begin
            if (active && sel_itcm) begin
                data_sel <= SEL_ITCM;
            end else if (active && sel_dtcm) begin
                data_sel <= SEL_DTCM;
            end else begin
                // Idle and unmapped both answered by the default slave
                data_sel <= SEL_DEFAULT;
            end
        end
    end

endmodule : ahb_decoder

`default_nettype wire

// File: src/ahb_to_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module ahb_to_sram
    import soc_pkg::*;
#(
    parameter int AW = 14
) (
    input  logic                clk      ,
    input  logic                rst_n    ,
    // AHB side
    input  logic                hsel     ,
    input  logic                hready_in,
    input  htrans_e             htrans   ,
    input  hsize_e              hsize    ,
    input  logic                hwrite   ,
    input  logic [31:0]         haddr    ,
    input  logic [`HDATA_W-1:0] hwdata   ,
    output logic                hreadyout,
    output logic                hresp    ,
    output logic [`HDATA_W-1:0] hrdata   ,
    // SRAM side
    input  logic [`HDATA_W-1:0] ram_rdata,
    output logic                ram_cs   ,
    output logic [AW-1:0]       ram_addr ,
    output logic [3:0]          ram_we   ,
    output logic [`HDATA_W-1:0] ram_wdata
);

    logic        accept;
    logic        rd_issue;
    logic [AW-1:0] addr_q;
    logic [3:0]  be_q;
    sram_state_e state_q;
    sram_state_e state_d;

    function automatic logic [3:0] lane_mask(input hsize_e size, input logic [1:0] lo);
        case (size)
            SIZE_BYTE: lane_mask = 4'b0001 << lo;
            SIZE_HALF: lane_mask = lo[1] ? 4'b1100 : 4'b0011;
            default:   lane_mask = 4'b1111;
        endcase
    endfunction

    assign accept   = hsel && hready_in && ((htrans == NONSEQ) || (htrans == SEQ));
    // Port is free unless a write data phase is in progress
    assign rd_issue = accept && !hwrite && (state_q != ST_WRITE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_READ_WAIT: state_d = ST_IDLE;
            default: begin
                if (hready_in) begin
                    if (accept && hwrite) begin
                        state_d = ST_WRITE;
                    end else if (accept && (state_q == ST_WRITE)) begin
                        state_d = ST_READ_WAIT;
                    end else begin
                        state_d = ST_IDLE;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Write address, or a read held behind a write
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= haddr[AW+1:2];
            be_q   <= lane_mask(hsize, haddr[1:0]);
        end
    end

    always_comb begin
        ram_cs   = 1'b0;
        ram_addr = haddr[AW+1:2];
        ram_we   = 4'b0000;
        case (state_q)
            ST_WRITE: begin
                ram_cs   = 1'b1;
                ram_addr = addr_q;
                ram_we   = be_q;
            end
            ST_READ_WAIT: begin
                ram_cs   = 1'b1;
                ram_addr = addr_q;
            end
            default: begin
                // Read straight from the address phase
                ram_cs = rd_issue;
            end
        endcase
    end

    assign ram_wdata = hwdata;
    assign hrdata    = ram_rdata;
    assign hreadyout = (state_q != ST_READ_WAIT);
    assign hresp     = 1'b0;

endmodule : ahb_to_sram

`default_nettype wire

// File: src/tcm_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module tcm_ram #(
    parameter int AW = 14
) (
    input  logic                clk  ,
    input  logic                cs   ,
    input  logic [AW-1:0]       addr ,
    input  logic [3:0]          we   ,
    input  logic [`HDATA_W-1:0] wdata,
    output logic [`HDATA_W-1:0] rdata
);

    logic [`HDATA_W-1:0] mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (|we) begin
                for (int i = 0; i < 4; i++) begin
                    if (we[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule : tcm_ram

`default_nettype wire

// File: src/ahb_default_slave.sv
`timescale 1ns/100ps
`default_nettype none

module ahb_default_slave
    import soc_pkg::*;
(
    input  logic    clk      ,
    input  logic    rst_n    ,
    input  logic    hsel     ,
    input  logic    hready_in,
    input  htrans_e htrans   ,
    output logic    hreadyout,
    output logic    hresp
);

    logic       start;
    logic       resp_q;
    err_state_e state_q;

    assign start = hsel && hready_in && ((htrans == NONSEQ) || (htrans == SEQ));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ERR_IDLE;
            resp_q  <= 1'b0;
        end else begin
            case (state_q)
                ERR_FIRST: begin
                    // Second cycle keeps the error response
                    state_q <= ERR_IDLE;
                    resp_q  <= 1'b1;
                end
                default: begin
                    state_q <= start ? ERR_FIRST : ERR_IDLE;
                    resp_q  <= start;
                end
            endcase
        end
    end

    assign hreadyout = (state_q != ERR_FIRST);
    assign hresp     = resp_q;

endmodule : ahb_default_slave

`default_nettype wire

// File: src/ahb_resp_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module ahb_resp_mux
    import soc_pkg::*;
(
    input  slave_sel_e          data_sel      ,
    input  logic                hreadyout_itcm,
    input  logic                hresp_itcm    ,
    input  logic [`HDATA_W-1:0] hrdata_itcm   ,
    input  logic                hreadyout_dtcm,
    input  logic                hresp_dtcm    ,
    input  logic [`HDATA_W-1:0] hrdata_dtcm   ,
    input  logic                hreadyout_def ,
    input  logic                hresp_def     ,
    output logic [`HDATA_W-1:0] hrdata        ,
    output logic                hready        ,
    output logic                hresp
);

    always_comb begin
        case (data_sel)
            SEL_ITCM: begin
                hrdata = hrdata_itcm;
                hready = hreadyout_itcm;
                hresp  = hresp_itcm;
            end
            SEL_DTCM: begin
                hrdata = hrdata_dtcm;
                hready = hreadyout_dtcm;
                hresp  = hresp_dtcm;
            end
            default: begin
                // No read data from unmapped space
                hrdata = '0;
                hready = hreadyout_def;
                hresp  = hresp_def;
            end
        endcase
    end

endmodule : ahb_resp_mux

`default_nettype wire

// File: src/soc.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module soc
    import soc_pkg::*;
(
    input  logic                clk   ,
    input  logic                rst_n ,
    input  logic [31:0]         haddr ,
    input  htrans_e             htrans,
    input  logic                hwrite,
    input  hsize_e              hsize ,
    input  logic [`HDATA_W-1:0] hwdata,
    output logic [`HDATA_W-1:0] hrdata,
    output logic                hready,
    output logic                hresp
);

    logic                sel_itcm      ;
    logic                sel_dtcm      ;
    logic                sel_default   ;
    slave_sel_e          data_sel      ;

    logic                hreadyout_itcm;
    logic                hresp_itcm    ;
    logic [`HDATA_W-1:0] hrdata_itcm   ;
    logic                itcm_cs       ;
    logic [`ITCM_AW-1:0] itcm_addr     ;
    logic [3:0]          itcm_we       ;
    logic [`HDATA_W-1:0] itcm_wdata    ;
    logic [`HDATA_W-1:0] itcm_rdata    ;

    logic                hreadyout_dtcm;
    logic                hresp_dtcm    ;
    logic [`HDATA_W-1:0] hrdata_dtcm   ;
    logic                dtcm_cs       ;
    logic [`DTCM_AW-1:0] dtcm_addr     ;
    logic [3:0]          dtcm_we       ;
    logic [`HDATA_W-1:0] dtcm_wdata    ;
    logic [`HDATA_W-1:0] dtcm_rdata    ;

    logic                hreadyout_def ;
    logic                hresp_def     ;

    ahb_decoder u_decoder (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .haddr      (haddr      ),
        .htrans     (htrans     ),
        .hready     (hready     ),
        .sel_itcm   (sel_itcm   ),
        .sel_dtcm   (sel_dtcm   ),
        .sel_default(sel_default),
        .data_sel   (data_sel   )
    );

    ahb_to_sram #(.AW(`ITCM_AW)) u_ahb_itcm (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .hsel     (sel_itcm      ),
        .hready_in(hready        ),
        .htrans   (htrans        ),
        .hsize    (hsize         ),
        .hwrite   (hwrite        ),
        .haddr    (haddr         ),
        .hwdata   (hwdata        ),
        .hreadyout(hreadyout_itcm),
        .hresp    (hresp_itcm    ),
        .hrdata   (hrdata_itcm   ),
        .ram_rdata(itcm_rdata    ),
        .ram_cs   (itcm_cs       ),
        .ram_addr (itcm_addr     ),
        .ram_we   (itcm_we       ),
        .ram_wdata(itcm_wdata    )
    );

    tcm_ram #(.AW(`ITCM_AW)) u_itcm (
        .clk  (clk       ),
        .cs   (itcm_cs   ),
        .addr (itcm_addr ),
        .we   (itcm_we   ),
        .wdata(itcm_wdata),
        .rdata(itcm_rdata)
    );

    ahb_to_sram #(.AW(`DTCM_AW)) u_ahb_dtcm (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .hsel     (sel_dtcm      ),
        .hready_in(hready        ),
        .htrans   (htrans        ),
        .hsize    (hsize         ),
        .hwrite   (hwrite        ),
        .haddr    (haddr         ),
        .hwdata   (hwdata        ),
        .hreadyout(hreadyout_dtcm),
        .hresp    (hresp_dtcm    ),
        .hrdata   (hrdata_dtcm   ),
        .ram_rdata(dtcm_rdata    ),
        .ram_cs   (dtcm_cs       ),
        .ram_addr (dtcm_addr     ),
        .ram_we   (dtcm_we       ),
        .ram_wdata(dtcm_wdata    )
    );

    tcm_ram #(.AW(`DTCM_AW)) u_dtcm (
        .clk  (clk       ),
        .cs   (dtcm_cs   ),
        .addr (dtcm_addr ),
        .we   (dtcm_we   ),
        .wdata(dtcm_wdata),
        .rdata(dtcm_rdata)
    );

    // Catches everything outside the two TCMs
    ahb_default_slave u_default (
        .clk      (clk          ),
        .rst_n    (rst_n        ),
        .hsel     (sel_default  ),
        .hready_in(hready       ),
        .htrans   (htrans       ),
        .hreadyout(hreadyout_def),
        .hresp    (hresp_def    )
    );

    ahb_resp_mux u_resp_mux (
        .data_sel      (data_sel      ),
        .hreadyout_itcm(hreadyout_itcm),
        .hresp_itcm    (hresp_itcm    ),
        .hrdata_itcm   (hrdata_itcm   ),
        .hreadyout_dtcm(hreadyout_dtcm),
        .hresp_dtcm    (hresp_dtcm    ),
        .hrdata_dtcm   (hrdata_dtcm   ),
        .hreadyout_def (hreadyout_def ),
        .hresp_def     (hresp_def     ),
        .hrdata        (hrdata        ),
        .hready        (hready        ),
        .hresp         (hresp         )
    );

endmodule : soc

`default_nettype wire

// File: sim/tb_soc.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_macros.svh"

module tb_soc
    import soc_pkg::*;
();

    typedef struct packed {
        logic        wr;
        hsize_e      size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        b2b;
        logic        exp_resp;
    } entry_t;

    logic                clk;
    logic                rst_n;
    logic [31:0]         haddr;
    htrans_e             htrans;
    logic                hwrite;
    hsize_e              hsize;
    logic [`HDATA_W-1:0] hwdata;
    logic [`HDATA_W-1:0] hrdata;
    logic                hready;
    logic                hresp;

    entry_t      tbl[$];
    int          seg_lo[2:7];
    logic [31:0] model[logic [31:0]];
    entry_t      pend;
    logic        pend_valid;
    logic        timed_out;
    int          checks;
    int          errors;
    int          test_errors;

    soc u_dut (
        .clk   (clk   ),
        .rst_n (rst_n ),
        .haddr (haddr ),
        .htrans(htrans),
        .hwrite(hwrite),
        .hsize (hsize ),
        .hwdata(hwdata),
        .hrdata(hrdata),
        .hready(hready),
        .hresp (hresp )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic string test_name(input int t);
        case (t)
            1: return "reset state";
            2: return "word write and read";
            3: return "byte and halfword lanes";
            4: return "read after write";
            5: return "unmapped error";
            default: return "random traffic";
        endcase
    endfunction

    // Bytes covered by an aligned transfer, as a bit mask over the word
    function automatic logic [31:0] byte_lanes(input hsize_e size, input logic [1:0] offset);
        int          nbytes;
        int          off;
        logic [31:0] m;
        nbytes = 1 << int'(size);
        off    = int'(offset);
        m      = '0;
        for (int b = 0; b < 4; b++) begin
            if (b >= off && b < off + nbytes) begin
                m[8*b +: 8] = 8'hFF;
            end
        end
        return m;
    endfunction

    task automatic build_table();
        logic [31:0] pool[16];
        entry_t      e;
        logic [2:0]  sz;
        seg_lo[2] = tbl.size();
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0000, 32'h0123_4567, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0004, 32'h89AB_CDEF, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_FFFC, 32'hDEAD_BEEF, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h2000_0000, 32'h0BAD_F00D, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h2000_7FFC, 32'hCAFE_F00D, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0000, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0004, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_FFFC, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h2000_0000, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h2000_7FFC, 32'h0, 1'b0, 1'b0});
        seg_lo[3] = tbl.size();
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0100, 32'h1122_3344, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_BYTE, 32'h0000_0101, 32'h0000_AB00, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_HALF, 32'h0000_0102, 32'hCDEF_0000, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_BYTE, 32'h0000_0100, 32'h0000_005A, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0100, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h2000_0200, 32'hA5A5_A5A5, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_HALF, 32'h2000_0200, 32'h0000_1234, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_BYTE, 32'h2000_0203, 32'h7700_0000, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h2000_0200, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_BYTE, 32'h2000_0202, 32'h0, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_HALF, 32'h2000_0202, 32'h0, 1'b0, 1'b0});
        seg_lo[4] = tbl.size();
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0040, 32'h5555_AAAA, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0040, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h2000_0040, 32'h3C3C_C3C3, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h2000_0040, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0080, 32'h1111_1111, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0084, 32'h2222_2222, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0080, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0084, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_BYTE, 32'h2000_0041, 32'h0000_9900, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_HALF, 32'h2000_0040, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0088, 32'h7777_8888, 1'b0, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h2000_0040, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0088, 32'h0, 1'b1, 1'b0});
        seg_lo[5] = tbl.size();
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h4000_0000, 32'h0, 1'b0, 1'b1});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0000, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'hF000_0010, 32'hFFFF_FFFF, 1'b0, 1'b1});
        tbl.push_back(entry_t'{1'b1, SIZE_WORD, 32'h0000_0200, 32'h600D_600D, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h0000_0200, 32'h0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{1'b0, SIZE_BYTE, 32'h1000_0003, 32'h0, 1'b0, 1'b1});
        tbl.push_back(entry_t'{1'b0, SIZE_WORD, 32'h2000_0000, 32'h0, 1'b0, 1'b0});
        seg_lo[6] = tbl.size();
        // Word pool, half in each TCM, filled before the random traffic
        for (int i = 0; i < 16; i++) begin
            if (i < 8) begin
                pool[i] = `ITCM_BASE + ($urandom_range((1 << `ITCM_AW) - 1, 0) << 2);
            end else begin
                pool[i] = `DTCM_BASE + ($urandom_range((1 << `DTCM_AW) - 1, 0) << 2);
            end
            tbl.push_back(entry_t'{1'b1, SIZE_WORD, pool[i], $urandom(), (i != 0), 1'b0});
        end
        for (int i = 0; i < 64; i++) begin
            sz         = 3'($urandom_range(2, 0));
            e.size     = hsize_e'(sz);
            e.addr     = pool[$urandom_range(15, 0)];
            if (e.size == SIZE_BYTE) begin
                e.addr[1:0] = 2'($urandom_range(3, 0));
            end else if (e.size == SIZE_HALF) begin
                e.addr[1] = 1'($urandom_range(1, 0));
            end
            e.wr       = 1'($urandom_range(1, 0));
            e.wdata    = $urandom();
            e.b2b      = 1'b1;
            e.exp_resp = 1'b0;
            tbl.push_back(e);
        end
        seg_lo[7] = tbl.size();
    endtask

    // Runs cycles until an edge with hready high, sampling on the falling edge
    task automatic wait_ready(output int waits, output logic first_resp, output logic any_resp,
                              output logic resp, output logic [31:0] rdata);
        logic ready_s;
        waits      = 0;
        first_resp = 1'b0;
        any_resp   = 1'b0;
        resp       = 1'b0;
        rdata      = '0;
        ready_s    = 1'b0;
        while (!ready_s && !timed_out) begin
            @(negedge clk);
            ready_s = hready;
            resp    = hresp;
            rdata   = hrdata;
            any_resp = any_resp | resp;
            if (!ready_s) begin
                if (waits == 0) begin
                    first_resp = resp;
                end
                waits++;
                if (waits >= 20) begin
                    $display("timeout: hready stayed low for 20 cycles at %0t", $time);
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);
        end
    endtask

    task automatic check_done(input entry_t e, input int waits, input logic first_resp,
                              input logic any_resp, input logic resp, input logic [31:0] rdata);
        logic [31:0] key;
        logic [31:0] mask;
        logic [31:0] exp;
        key  = {e.addr[31:2], 2'b00};
        mask = byte_lanes(e.size, e.addr[1:0]);
        checks++;
        assert (resp == e.exp_resp) else begin
            $display("error: t=%0t hresp expected %0b got %0b at %08h", $time, e.exp_resp,
                     resp, e.addr);
            test_errors++;
        end
        if (e.exp_resp) begin
            assert (waits == 1 && first_resp) else begin
                $display("error response at %08h was not one wait cycle with hresp high",
                         e.addr);
                test_errors++;
            end
            // Unmapped space reads back as zero on the whole bus
            exp  = '0;
            mask = '1;
        end else begin
            assert (!any_resp) else begin
                $display("hresp went high during the OKAY transfer at %08h", e.addr);
                test_errors++;
            end
            exp = model.exists(key) ? model[key] : '0;
            if (e.wr) begin
                model[key] = (exp & ~mask) | (e.wdata & mask);
            end
        end
        if (!e.wr) begin
            assert ((rdata & mask) == (exp & mask)) else begin
                $display("error: t=%0t hrdata at %08h expected %08h got %08h", $time, e.addr,
                         exp & mask, rdata & mask);
                test_errors++;
            end
        end
    endtask

    // One address phase, or IDLE, which also ends the data phase in flight
    task automatic step(input logic active, input entry_t e);
        int          waits;
        logic        first_resp;
        logic        any_resp;
        logic        resp;
        logic [31:0] rdata;
        haddr  <= e.addr;
        hwrite <= e.wr;
        hsize  <= e.size;
        if (active) begin
            htrans <= NONSEQ;
        end else begin
            htrans <= IDLE;
        end
        wait_ready(waits, first_resp, any_resp, resp, rdata);
        if (timed_out) begin
            return;
        end
        if (pend_valid) begin
            check_done(pend, waits, first_resp, any_resp, resp, rdata);
        end
        pend_valid = active;
        pend       = e;
        if (active && e.wr) begin
            hwdata <= e.wdata;
        end
    endtask

    initial begin
        void'($urandom(32'hcdd4));
        rst_n       = 1'b0;
        haddr       = '0;
        htrans      = IDLE;
        hwrite      = 1'b0;
        hsize       = SIZE_WORD;
        hwdata      = '0;
        pend_valid  = 1'b0;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        test_errors = 0;
        checks += 2;
        assert (hready === 1'b1) else begin
            $display("error: t=%0t hready expected 1 got %b", $time, hready);
            test_errors++;
        end
        assert (hresp === 1'b0) else begin
            $display("error: t=%0t hresp expected 0 got %b", $time, hresp);
            test_errors++;
        end
        errors += test_errors;
        $display("test 1 %s: %0d errors", test_name(1), test_errors);
        @(posedge clk);

        for (int t = 2; t <= 6; t++) begin
            test_errors = 0;
            for (int i = seg_lo[t]; i < seg_lo[t+1] && !timed_out; i++) begin
                if (!tbl[i].b2b) begin
                    step(1'b0, '0);
                end
                if (!timed_out) begin
                    step(1'b1, tbl[i]);
                end
            end
            // Drain the last data phase
            if (!timed_out) begin
                step(1'b0, '0);
            end
            errors += test_errors;
            $display("test %0d %s: %0d errors", t, test_name(t), test_errors);
            if (timed_out) begin
                break;
            end
        end

        $display("checks %0d, errors %0d, timeout %0b", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_soc

`default_nettype wire

// File: sim.f
+incdir+src
src/soc_pkg.sv
src/ahb_decoder.sv
src/ahb_to_sram.sv
src/tcm_ram.sv
src/ahb_default_slave.sv
src/ahb_resp_mux.sv
src/soc.sv
sim/tb_soc.sv

// File: run_sim.sh
#!/bin/sh
# Builds the SoC testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc -f sim.f -Mdir "$build_dir" -o sim_soc
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/sim_soc" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0
